//--- Bender.yml
package:
  name: sched_front

sources:
  - sched_cfg_pkg.sv
  - sched_types_pkg.sv
  - rename_stage.sv
  - dispatch_queue.sv
  - issue_stage.sv
  - scheduler_top.sv
  - target: test
    files:
      - tb_scheduler_asserts.sv
      - tb_scheduler.sv

//--- dispatch_queue.sv
// circular dispatch queue between rename and issue, read as first word fall-through
`timescale 1ns/1ps

module dispatch_queue
  import sched_cfg_pkg::*;
  import sched_types_pkg::*;
#(
  parameter int DEPTH = DQ_DEPTH
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      push_i,
  input  dq_entry_t push_data_i,
  output logic      full_o,
  input  logic      pop_i,
  output logic      empty_o,
  output dq_entry_t head_o
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  dq_entry_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  always_comb begin
    full_o  = (count == CNT_W'(DEPTH));
    empty_o = (count == '0);
    do_push = push_i & ~full_o;
    do_pop  = pop_i & ~empty_o;
    head_o  = mem[rd_ptr];
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  // pointers wrap at DEPTH
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- files.f
sched_cfg_pkg.sv
sched_types_pkg.sv
rename_stage.sv
dispatch_queue.sv
issue_stage.sv
scheduler_top.sv
tb_scheduler_asserts.sv
tb_scheduler.sv

//--- issue_stage.sv
// issue stage that routes queue heads by class and issues each class in order when its sources are ready
`timescale 1ns/1ps

module issue_stage
  import sched_cfg_pkg::*;
  import sched_types_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      dq_empty_i,
  input  dq_entry_t dq_head_i,
  output logic      dq_pop_o,
  input  logic      wb_valid_i,
  input  preg_t     wb_preg_i,
  input  logic      alu_ready_i,
  input  logic      mem_ready_i,
  output logic      alu_valid_o,
  output preg_t     alu_dest_o,
  output preg_t     alu_src0_o,
  output preg_t     alu_src1_o,
  output imm_t      alu_imm_o,
  output logic      mem_valid_o,
  output preg_t     mem_dest_o,
  output preg_t     mem_src0_o,
  output preg_t     mem_src1_o,
  output imm_t      mem_imm_o
);

  localparam int NUM_CLASS = 2;
  localparam int IQ_PTR_W  = $clog2(IQ_DEPTH);
  localparam int IQ_CNT_W  = $clog2(IQ_DEPTH + 1);

  logic [PREG_NUM-1:0] busy;

  // one in-order queue per class, pointers wrap at IQ_DEPTH
  dq_entry_t           iq_mem [NUM_CLASS][IQ_DEPTH];
  logic [IQ_PTR_W-1:0] iq_rd  [NUM_CLASS];
  logic [IQ_PTR_W-1:0] iq_wr  [NUM_CLASS];
  logic [IQ_CNT_W-1:0] iq_cnt [NUM_CLASS];

  iclass_t              head_class;
  logic [NUM_CLASS-1:0] unit_ready;
  logic [NUM_CLASS-1:0] iq_push;
  logic [NUM_CLASS-1:0] iq_fire;
  logic [NUM_CLASS-1:0] src0_ok;
  logic [NUM_CLASS-1:0] src1_ok;
  dq_entry_t            iq_head [NUM_CLASS];
  preg_t                src0_tag [NUM_CLASS];
  preg_t                src1_tag [NUM_CLASS];

  logic [NUM_CLASS-1:0] iss_valid_q;
  preg_t                iss_dest_q [NUM_CLASS];
  preg_t                iss_src0_q [NUM_CLASS];
  preg_t                iss_src1_q [NUM_CLASS];
  imm_t                 iss_imm_q  [NUM_CLASS];

  // ====================
  // routing and select
  // ====================

  always_comb begin
    unit_ready[CLASS_ALU] = alu_ready_i;
    unit_ready[CLASS_MEM] = mem_ready_i;
    head_class = dq_head_i[DQ_CLASS];
    // head waits while its class queue is full
    dq_pop_o = ~dq_empty_i & (iq_cnt[head_class] != IQ_CNT_W'(IQ_DEPTH));
    for (int c = 0; c < NUM_CLASS; c++) begin
      iq_push[c]  = dq_pop_o & (head_class == iclass_t'(c));
      iq_head[c]  = iq_mem[c][iq_rd[c]];
      src0_tag[c] = iq_head[c][DQ_SRC0_LSB +: PREG_W];
      src1_tag[c] = iq_head[c][DQ_SRC1_LSB +: PREG_W];
      // a writeback in this cycle frees its tag before the busy table clears
      src0_ok[c]  = ~iq_head[c][DQ_SRC0_USED] | ~busy[src0_tag[c]]
                    | (wb_valid_i & (wb_preg_i == src0_tag[c]));
      src1_ok[c]  = ~iq_head[c][DQ_SRC1_USED] | ~busy[src1_tag[c]]
                    | (wb_valid_i & (wb_preg_i == src1_tag[c]));
      iq_fire[c]  = (iq_cnt[c] != '0) & src0_ok[c] & src1_ok[c] & unit_ready[c];
    end
  end

  always_ff @(posedge clk) begin
    for (int c = 0; c < NUM_CLASS; c++) begin
      if (iq_push[c]) begin
        iq_mem[c][iq_wr[c]] <= dq_head_i;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int c = 0; c < NUM_CLASS; c++) begin
        iq_rd[c]  <= '0;
        iq_wr[c]  <= '0;
        iq_cnt[c] <= '0;
      end
    end else begin
      for (int c = 0; c < NUM_CLASS; c++) begin
        if (iq_push[c]) begin
          iq_wr[c] <= iq_wr[c] + 1'b1;
        end
        if (iq_fire[c]) begin
          iq_rd[c] <= iq_rd[c] + 1'b1;
        end
        case ({iq_push[c], iq_fire[c]})
          2'b10:   iq_cnt[c] <= iq_cnt[c] + 1'b1;
          2'b01:   iq_cnt[c] <= iq_cnt[c] - 1'b1;
          default: iq_cnt[c] <= iq_cnt[c];
        endcase
      end
    end
  end

  // ====================
  // busy table
  // ====================

  // set on dispatch wins over a clear of the same tag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= '0;
    end else begin
      if (wb_valid_i) begin
        busy[wb_preg_i] <= 1'b0;
      end
      if (dq_pop_o && dq_head_i[DQ_DEST_USED]) begin
        busy[dq_head_i[DQ_DEST_LSB +: PREG_W]] <= 1'b1;
      end
    end
  end

  // ====================
  // issue registers
  // ====================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      iss_valid_q <= '0;
      for (int c = 0; c < NUM_CLASS; c++) begin
        iss_dest_q[c] <= '0;
        iss_src0_q[c] <= '0;
        iss_src1_q[c] <= '0;
        iss_imm_q[c]  <= '0;
      end
    end else begin
      iss_valid_q <= iq_fire;
      for (int c = 0; c < NUM_CLASS; c++) begin
        if (iq_fire[c]) begin
          iss_dest_q[c] <= iq_head[c][DQ_DEST_LSB +: PREG_W];
          iss_src0_q[c] <= iq_head[c][DQ_SRC0_LSB +: PREG_W];
          iss_src1_q[c] <= iq_head[c][DQ_SRC1_LSB +: PREG_W];
          iss_imm_q[c]  <= iq_head[c][DQ_IMM_LSB +: IMM_W];
        end
      end
    end
  end

  assign alu_valid_o = iss_valid_q[CLASS_ALU];
  assign alu_dest_o  = iss_dest_q[CLASS_ALU];
  assign alu_src0_o  = iss_src0_q[CLASS_ALU];
  assign alu_src1_o  = iss_src1_q[CLASS_ALU];
  assign alu_imm_o   = iss_imm_q[CLASS_ALU];
  assign mem_valid_o = iss_valid_q[CLASS_MEM];
  assign mem_dest_o  = iss_dest_q[CLASS_MEM];
  assign mem_src0_o  = iss_src0_q[CLASS_MEM];
  assign mem_src1_o  = iss_src1_q[CLASS_MEM];
  assign mem_imm_o   = iss_imm_q[CLASS_MEM];

endmodule

//--- rename_stage.sv
// rename stage that maps registers to physical tags and writes renamed entries into the dispatch queue
`timescale 1ns/1ps

module rename_stage
  import sched_cfg_pkg::*;
  import sched_types_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  // decoded instruction
  input  logic      in_valid_i,
  input  iclass_t   in_class_i,
  input  areg_t     in_dest_i,
  input  areg_t     in_src0_i,
  input  areg_t     in_src1_i,
  input  imm_t      in_imm_i,
  output logic      in_ready_o,
  // tags returned at retirement
  input  logic      free_valid_i,
  input  preg_t     free_preg_i,
  // dispatch queue write side
  input  logic      dq_full_i,
  output logic      dq_push_o,
  output dq_entry_t dq_push_data_o
);

  localparam int FL_CNT_W  = $clog2(PREG_NUM + 1);
  localparam int INIT_FREE = PREG_NUM - ARCH_REG_NUM;

  // free list storage, pointers wrap at PREG_NUM
  preg_t               fl_mem [PREG_NUM];
  logic [PREG_W-1:0]   fl_head;
  logic [PREG_W-1:0]   fl_tail;
  logic [FL_CNT_W-1:0] fl_count;

  // speculative rename table
  preg_t rat [ARCH_REG_NUM];

  logic  dest_used;
  logic  src0_used;
  logic  src1_used;
  logic  accept;
  logic  alloc;
  preg_t new_dest;
  preg_t src0_preg;
  preg_t src1_preg;

  // ====================
  // lookup and handshake
  // ====================

  always_comb begin
    dest_used  = (in_dest_i != '0);
    src0_used  = (in_src0_i != '0);
    src1_used  = (in_src1_i != '0);
    // only a real destination needs a free tag
    in_ready_o = ~dq_full_i & (~dest_used | (fl_count != '0));
    accept     = in_valid_i & in_ready_o;
    alloc      = accept & dest_used;
    new_dest   = fl_mem[fl_head];
    // table is read before this cycle's update
    src0_preg  = rat[in_src0_i];
    src1_preg  = rat[in_src1_i];
  end

  always_comb begin
    dq_push_o      = accept;
    dq_push_data_o = '0;
    dq_push_data_o[DQ_CLASS]              = in_class_i;
    dq_push_data_o[DQ_SRC0_LSB +: PREG_W] = src0_preg;
    dq_push_data_o[DQ_SRC0_USED]          = src0_used;
    dq_push_data_o[DQ_SRC1_LSB +: PREG_W] = src1_preg;
    dq_push_data_o[DQ_SRC1_USED]          = src1_used;
    dq_push_data_o[DQ_DEST_LSB +: PREG_W] = dest_used ? new_dest : '0;
    dq_push_data_o[DQ_DEST_USED]          = dest_used;
    dq_push_data_o[DQ_IMM_LSB +: IMM_W]   = in_imm_i;
  end

  // ====================
  // free list
  // ====================

  // upper tags start free in ascending order
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < PREG_NUM; i++) begin
        fl_mem[i] <= (i < INIT_FREE) ? preg_t'(ARCH_REG_NUM + i) : '0;
      end
      fl_head  <= '0;
      fl_tail  <= PREG_W'(INIT_FREE);
      fl_count <= FL_CNT_W'(INIT_FREE);
    end else begin
      if (free_valid_i) begin
        fl_mem[fl_tail] <= free_preg_i;
        fl_tail         <= fl_tail + 1'b1;
      end
      if (alloc) begin
        fl_head <= fl_head + 1'b1;
      end
      case ({free_valid_i, alloc})
        2'b10:   fl_count <= fl_count + 1'b1;
        2'b01:   fl_count <= fl_count - 1'b1;
        default: fl_count <= fl_count;
      endcase
    end
  end

  // ====================
  // rename table
  // ====================

  // r0 is never written since alloc needs a non-zero dest
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < ARCH_REG_NUM; i++) begin
        rat[i] <= preg_t'(i);
      end
    end else if (alloc) begin
      rat[in_dest_i] <= new_dest;
    end
  end

endmodule

//--- sched_cfg_pkg.sv
// sizes of register files, queues and tags for the rename and dispatch front, imported by all RTL
package sched_cfg_pkg;

  // ====================
  // register files
  // ====================

  // integer registers r0 to r31
  localparam int ARCH_REG_NUM = 32;
  // lower half starts mapped one to one
  localparam int PREG_NUM = 64;

  // ====================
  // queue depths
  // ====================

  localparam int DQ_DEPTH = 8;
  // per class in-order issue queue
  localparam int IQ_DEPTH = 4;

  // ====================
  // tag widths
  // ====================

  localparam int PREG_W = $clog2(PREG_NUM);
  localparam int AREG_W = $clog2(ARCH_REG_NUM);

endpackage

//--- sched_types_pkg.sv
// register tag, instruction class and dispatch entry types used by the RTL and the testbench
package sched_types_pkg;

  import sched_cfg_pkg::*;

  typedef logic [AREG_W-1:0] areg_t;
  typedef logic [PREG_W-1:0] preg_t;

  // 0 goes to the ALU and 1 to the memory unit
  typedef logic iclass_t;
  localparam iclass_t CLASS_ALU = 1'b0;
  localparam iclass_t CLASS_MEM = 1'b1;

  localparam int IMM_W = 16;
  typedef logic [IMM_W-1:0] imm_t;

  // ====================
  // dispatch entry
  // ====================

  // immediate in the low bits, class on top
  localparam int DQ_IMM_LSB   = 0;
  localparam int DQ_DEST_USED = DQ_IMM_LSB + IMM_W;
  localparam int DQ_DEST_LSB  = DQ_DEST_USED + 1;
  localparam int DQ_SRC1_USED = DQ_DEST_LSB + PREG_W;
  localparam int DQ_SRC1_LSB  = DQ_SRC1_USED + 1;
  localparam int DQ_SRC0_USED = DQ_SRC1_LSB + PREG_W;
  localparam int DQ_SRC0_LSB  = DQ_SRC0_USED + 1;
  localparam int DQ_CLASS     = DQ_SRC0_LSB + PREG_W;
  localparam int DQ_ENTRY_W   = DQ_CLASS + 1;

  typedef logic [DQ_ENTRY_W-1:0] dq_entry_t;

endpackage

//--- scheduler_tests.txt
# I class dest src0 src1 imm | W tag | F tag | S unit cycles | E class dest src0 src1
# T starts a named test, R checks in_ready_o; class and unit 0 is ALU, 1 is memory; imm in hex
T rename
R 1
I 0 1 0 0 0001
E 0 32 0 0
W 32
I 0 2 1 3 0002
E 0 33 32 3
W 33
I 0 1 1 2 0003
E 0 34 32 33
W 34
I 1 0 1 0 0004
E 1 0 34 0
T depend
I 1 5 0 0 0010
E 1 35 0 0
I 0 6 5 0 0011
I 1 7 0 0 0012
E 1 37 0 0
W 35
E 0 36 35 0
W 36
W 37
T order
I 1 8 0 0 0020
E 1 38 0 0
I 0 9 8 0 0021
I 0 10 0 0 0022
W 38
E 0 39 38 0
E 0 40 0 0
W 39
W 40
T backpressure
S 1 100
I 1 11 0 0 0030
I 1 12 0 0 0031
I 1 13 0 0 0032
I 1 14 0 0 0033
I 1 15 0 0 0034
I 1 16 0 0 0035
I 1 17 0 0 0036
I 1 18 0 0 0037
I 1 19 0 0 0038
I 1 20 0 0 0039
I 1 21 0 0 003a
I 1 22 0 0 003b
R 0
E 1 41 0 0
E 1 42 0 0
E 1 43 0 0
E 1 44 0 0
E 1 45 0 0
E 1 46 0 0
E 1 47 0 0
E 1 48 0 0
E 1 49 0 0
E 1 50 0 0
E 1 51 0 0
E 1 52 0 0
T freelist
I 0 23 0 0 0040
I 0 24 0 0 0041
I 0 25 0 0 0042
I 0 26 0 0 0043
I 0 27 0 0 0044
I 0 28 0 0 0045
I 0 29 0 0 0046
I 0 30 0 0 0047
I 0 31 0 0 0048
I 0 3 0 0 0049
I 0 4 0 0 004a
R 0
E 0 53 0 0
E 0 54 0 0
E 0 55 0 0
E 0 56 0 0
E 0 57 0 0
E 0 58 0 0
E 0 59 0 0
E 0 60 0 0
E 0 61 0 0
E 0 62 0 0
E 0 63 0 0
F 32
R 1
I 0 5 0 0 0050
E 0 32 0 0

//--- scheduler_top.sv
// top of the rename and dispatch front, connecting rename, dispatch queue and issue
`timescale 1ns/1ps

module scheduler_top
  import sched_cfg_pkg::*;
  import sched_types_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    in_valid_i,
  input  iclass_t in_class_i,
  input  areg_t   in_dest_i,
  input  areg_t   in_src0_i,
  input  areg_t   in_src1_i,
  input  imm_t    in_imm_i,
  output logic    in_ready_o,
  input  logic    wb_valid_i,
  input  preg_t   wb_preg_i,
  input  logic    free_valid_i,
  input  preg_t   free_preg_i,
  input  logic    alu_ready_i,
  input  logic    mem_ready_i,
  output logic    alu_valid_o,
  output preg_t   alu_dest_o,
  output preg_t   alu_src0_o,
  output preg_t   alu_src1_o,
  output imm_t    alu_imm_o,
  output logic    mem_valid_o,
  output preg_t   mem_dest_o,
  output preg_t   mem_src0_o,
  output preg_t   mem_src1_o,
  output imm_t    mem_imm_o
);

  logic      dq_push;
  dq_entry_t dq_push_data;
  logic      dq_full;
  logic      dq_pop;
  logic      dq_empty;
  dq_entry_t dq_head;

  // producer
  rename_stage u_rename_stage (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid_i     (in_valid_i),
    .in_class_i     (in_class_i),
    .in_dest_i      (in_dest_i),
    .in_src0_i      (in_src0_i),
    .in_src1_i      (in_src1_i),
    .in_imm_i       (in_imm_i),
    .in_ready_o     (in_ready_o),
    .free_valid_i   (free_valid_i),
    .free_preg_i    (free_preg_i),
    .dq_full_i      (dq_full),
    .dq_push_o      (dq_push),
    .dq_push_data_o (dq_push_data)
  );

  dispatch_queue #(
    .DEPTH (DQ_DEPTH)
  ) u_dispatch_queue (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (dq_push),
    .push_data_i (dq_push_data),
    .full_o      (dq_full),
    .pop_i       (dq_pop),
    .empty_o     (dq_empty),
    .head_o      (dq_head)
  );

  // consumer
  issue_stage u_issue_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .dq_empty_i  (dq_empty),
    .dq_head_i   (dq_head),
    .dq_pop_o    (dq_pop),
    .wb_valid_i  (wb_valid_i),
    .wb_preg_i   (wb_preg_i),
    .alu_ready_i (alu_ready_i),
    .mem_ready_i (mem_ready_i),
    .alu_valid_o (alu_valid_o),
    .alu_dest_o  (alu_dest_o),
    .alu_src0_o  (alu_src0_o),
    .alu_src1_o  (alu_src1_o),
    .alu_imm_o   (alu_imm_o),
    .mem_valid_o (mem_valid_o),
    .mem_dest_o  (mem_dest_o),
    .mem_src0_o  (mem_src0_o),
    .mem_src1_o  (mem_src1_o),
    .mem_imm_o   (mem_imm_o)
  );

endmodule

//--- tb_scheduler.sv
// testbench for the scheduler front, reads scheduler_tests.txt and checks every issue per class
`timescale 1ns/1ps

module tb_scheduler
  import sched_types_pkg::*;
();

  localparam int          CYCLES_PER_LINE = 40;
  localparam int          TAG_W           = $bits(preg_t);
  localparam logic [31:0] LFSR_SEED       = 32'd77970;
  localparam logic [31:0] LFSR_TAPS       = 32'hA300_0000;

  // dest, src0, src1 and imm of one issue
  typedef logic [3*TAG_W+IMM_W-1:0] issue_rec_t;

  logic    clk = 1'b0;
  logic    rst_n;
  logic    in_valid;
  iclass_t in_class;
  areg_t   in_dest;
  areg_t   in_src0;
  areg_t   in_src1;
  imm_t    in_imm;
  logic    in_ready;
  logic    wb_valid;
  preg_t   wb_preg;
  logic    free_valid;
  preg_t   free_preg;
  logic    alu_ready;
  logic    mem_ready;
  logic    alu_valid;
  preg_t   alu_dest;
  preg_t   alu_src0;
  preg_t   alu_src1;
  imm_t    alu_imm;
  logic    mem_valid;
  preg_t   mem_dest;
  preg_t   mem_src0;
  preg_t   mem_src1;
  imm_t    mem_imm;

  string      lines [$];
  issue_rec_t alu_seen [$];
  issue_rec_t mem_seen [$];

  // immediates of accepted instructions in program order per class
  imm_t alu_imm_exp [$];
  imm_t mem_imm_exp [$];

  // tags issued as a destination and not yet written back
  logic [2**TAG_W-1:0] wb_pending = '0;

  logic [31:0] lfsr = LFSR_SEED;
  int cycle_cnt = 0;
  int cycle_limit = 0;
  int err_cnt = 0;
  int test_cnt = 0;
  int test_fail = 0;
  int test_err_base = 0;
  int alu_stall = 0;
  int mem_stall = 0;
  string test_name = "";

  always #5 clk = ~clk;

  scheduler_top dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid_i   (in_valid),
    .in_class_i   (in_class),
    .in_dest_i    (in_dest),
    .in_src0_i    (in_src0),
    .in_src1_i    (in_src1),
    .in_imm_i     (in_imm),
    .in_ready_o   (in_ready),
    .wb_valid_i   (wb_valid),
    .wb_preg_i    (wb_preg),
    .free_valid_i (free_valid),
    .free_preg_i  (free_preg),
    .alu_ready_i  (alu_ready),
    .mem_ready_i  (mem_ready),
    .alu_valid_o  (alu_valid),
    .alu_dest_o   (alu_dest),
    .alu_src0_o   (alu_src0),
    .alu_src1_o   (alu_src1),
    .alu_imm_o    (alu_imm),
    .mem_valid_o  (mem_valid),
    .mem_dest_o   (mem_dest),
    .mem_src0_o   (mem_src0),
    .mem_src1_o   (mem_src1),
    .mem_imm_o    (mem_imm)
  );

  // ====================
  // watchdog
  // ====================

  always @(posedge clk) begin
    if (rst_n) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
        $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
        $display("Checks failed");
        $finish;
      end
    end
  end

  // ====================
  // issue monitor
  // ====================

  // a source still waiting for its writeback must not issue
  function automatic void note_issue(string unit, preg_t dest, preg_t src0, preg_t src1);
    if (wb_pending[src0] || wb_pending[src1]) begin
      $display("ERR %0t: %s issued with source %0d or %0d before its writeback",
               $time, unit, src0, src1);
      err_cnt++;
    end
    if (dest != '0) begin
      wb_pending[dest] = 1'b1;
    end
  endfunction

  always @(negedge clk) begin
    if (rst_n) begin
      if (alu_valid) begin
        note_issue("ALU", alu_dest, alu_src0, alu_src1);
        alu_seen.push_back({alu_dest, alu_src0, alu_src1, alu_imm});
      end
      if (mem_valid) begin
        note_issue("memory", mem_dest, mem_src0, mem_src1);
        mem_seen.push_back({mem_dest, mem_src0, mem_src1, mem_imm});
      end
    end
  end

  // ====================
  // helpers
  // ====================

  function automatic logic rand_bit();
    logic out_bit;
    out_bit = lfsr[0];
    lfsr = lfsr >> 1;
    if (out_bit) begin
      lfsr = lfsr ^ LFSR_TAPS;
    end
    return out_bit;
  endfunction

  // unit stalls count down once per cycle
  task automatic step_cycle();
    @(posedge clk);
    #1;
    if (alu_stall > 0) begin
      alu_stall--;
    end
    if (mem_stall > 0) begin
      mem_stall--;
    end
    alu_ready = (alu_stall == 0);
    mem_ready = (mem_stall == 0);
  endtask

  task automatic load_tests(output logic ok);
    int    fd;
    int    code;
    string line;
    fd = $fopen("scheduler_tests.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      while (!$feof(fd)) begin
        line = "";
        code = $fgets(line, fd);
        if (code != 0 && line.len() > 1 && line[0] != "#") begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic close_test();
    int errs;
    if (test_name != "") begin
      errs = err_cnt - test_err_base;
      test_cnt++;
      if (errs != 0) begin
        test_fail++;
      end
      $display("test %s: %s, %0d errors", test_name, (errs == 0) ? "ok" : "FAIL", errs);
    end
    test_err_base = err_cnt;
  endtask

  task automatic drive_instr(int cls, int dest, int src0, int src1, int imm);
    logic taken;
    in_valid = 1'b1;
    in_class = iclass_t'(cls);
    in_dest  = areg_t'(dest);
    in_src0  = areg_t'(src0);
    in_src1  = areg_t'(src1);
    in_imm   = imm_t'(imm);
    taken    = 1'b0;
    // held until the rename stage takes it
    while (!taken) begin
      @(negedge clk);
      taken = in_ready;
      step_cycle();
    end
    in_valid = 1'b0;
    if (cls == 0) begin
      alu_imm_exp.push_back(imm_t'(imm));
    end else begin
      mem_imm_exp.push_back(imm_t'(imm));
    end
  endtask

  task automatic expect_issue(int cls, int dest, int src0, int src1);
    issue_rec_t want;
    issue_rec_t got;
    imm_t       imm;
    logic       have_instr;
    have_instr = 1'b0;
    imm        = '0;
    if (cls == 0 && alu_imm_exp.size() != 0) begin
      imm        = alu_imm_exp.pop_front();
      have_instr = 1'b1;
    end else if (cls != 0 && mem_imm_exp.size() != 0) begin
      imm        = mem_imm_exp.pop_front();
      have_instr = 1'b1;
    end
    want = {preg_t'(dest), preg_t'(src0), preg_t'(src1), imm};
    if (!have_instr) begin
      $display("an issue of class %0d is expected but no such instruction was driven", cls);
      err_cnt++;
    end else begin
      if (cls == 0) begin
        while (alu_seen.size() == 0) begin
          step_cycle();
        end
        got = alu_seen.pop_front();
      end else begin
        while (mem_seen.size() == 0) begin
          step_cycle();
        end
        got = mem_seen.pop_front();
      end
      if (got !== want) begin
        $display("ERR %0t: class %0d expected dest %0d src0 %0d src1 %0d imm %h, got %0d %0d %0d %h",
                 $time, cls, dest, src0, src1, imm,
                 got[IMM_W+2*TAG_W +: TAG_W], got[IMM_W+TAG_W +: TAG_W],
                 got[IMM_W +: TAG_W], got[0 +: IMM_W]);
        err_cnt++;
      end
    end
  endtask

  task automatic run_line(string line);
    string kind;
    string name;
    int    a;
    int    b;
    int    c;
    int    d;
    int    e;
    kind = line.substr(0, 0);
    case (kind)
      "T": begin
        close_test();
        void'($sscanf(line, "T %s", name));
        test_name = name;
      end
      "I": begin
        void'($sscanf(line, "I %d %d %d %d %h", a, b, c, d, e));
        drive_instr(a, b, c, d, e);
      end
      "W": begin
        void'($sscanf(line, "W %d", a));
        wb_valid = 1'b1;
        wb_preg  = preg_t'(a);
        wb_pending[a] = 1'b0;
        step_cycle();
        wb_valid = 1'b0;
      end
      "F": begin
        void'($sscanf(line, "F %d", a));
        free_valid = 1'b1;
        free_preg  = preg_t'(a);
        step_cycle();
        free_valid = 1'b0;
      end
      "S": begin
        void'($sscanf(line, "S %d %d", a, b));
        if (a == 0) begin
          alu_stall = b;
          alu_ready = (b == 0);
        end else begin
          mem_stall = b;
          mem_ready = (b == 0);
        end
      end
      "R": begin
        void'($sscanf(line, "R %d", a));
        @(negedge clk);
        if (in_ready !== logic'(a[0])) begin
          $display("ERR %0t: in_ready_o expected %0d, got %b", $time, a, in_ready);
          err_cnt++;
        end
        step_cycle();
      end
      "E": begin
        void'($sscanf(line, "E %d %d %d %d", a, b, c, d));
        expect_issue(a, b, c, d);
      end
      default: begin
        $display("test file holds a line of unknown kind: %s", line);
        err_cnt++;
      end
    endcase
  endtask

  // ====================
  // main sequence
  // ====================

  initial begin
    logic       ok;
    logic [1:0] idle;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_class   = CLASS_ALU;
    in_dest    = '0;
    in_src0    = '0;
    in_src1    = '0;
    in_imm     = '0;
    wb_valid   = 1'b0;
    wb_preg    = '0;
    free_valid = 1'b0;
    free_preg  = '0;
    alu_ready  = 1'b1;
    mem_ready  = 1'b1;
    load_tests(ok);
    if (!ok) begin
      $display("test file scheduler_tests.txt could not be opened");
      $display("Checks failed");
    end else begin
      cycle_limit = CYCLES_PER_LINE * lines.size();
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;
      foreach (lines[i]) begin
        run_line(lines[i]);
        // 0 to 3 idle cycles between lines
        idle[1] = rand_bit();
        idle[0] = rand_bit();
        repeat (idle) step_cycle();
      end
      repeat (20) step_cycle();
      if (alu_seen.size() != 0 || mem_seen.size() != 0) begin
        $display("%0d ALU and %0d memory issues came without an expected record",
                 alu_seen.size(), mem_seen.size());
        err_cnt++;
      end
      if (dut_i.u_issue_stage.u_asserts.assert_fail_cnt != 0) begin
        $display("%0d bound assertions failed during the run",
                 dut_i.u_issue_stage.u_asserts.assert_fail_cnt);
        err_cnt += dut_i.u_issue_stage.u_asserts.assert_fail_cnt;
      end
      close_test();
      $display("%0d tests run, %0d failed, %0d errors in total", test_cnt, test_fail, err_cnt);
      if (err_cnt == 0) begin
        $display("All checks passed");
      end else begin
        $display("Checks failed");
      end
    end
    $finish;
  end

endmodule

//--- tb_scheduler_asserts.sv
// concurrent checks on the issue stage handshakes, bound into every issue_stage instance
`timescale 1ns/1ps

module tb_scheduler_asserts
  import sched_cfg_pkg::*;
  import sched_types_pkg::*;
(
  input logic                        clk,
  input logic                        rst_n,
  input logic                        dq_empty_i,
  input logic                        dq_pop_i,
  input logic [$clog2(IQ_DEPTH)-1:0] alu_rd_i,
  input logic [$clog2(IQ_DEPTH)-1:0] mem_rd_i,
  input logic [PREG_NUM-1:0]         busy_i,
  input logic                        alu_valid_i,
  input preg_t                       alu_src0_i,
  input preg_t                       alu_src1_i,
  input logic                        mem_valid_i,
  input preg_t                       mem_src0_i,
  input preg_t                       mem_src1_i
);

  int assert_fail_cnt = 0;

  // ====================
  // properties
  // ====================

  pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
    dq_pop_i |-> !dq_empty_i)
    else begin
      assert_fail_cnt++;
      $error("dispatch queue popped while empty");
    end

  // a second valid cycle needs another entry to leave the issue queue
  alu_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    alu_valid_i |=> (!alu_valid_i || (alu_rd_i != $past(alu_rd_i))))
    else begin
      assert_fail_cnt++;
      $error("ALU valid held without a new issue");
    end

  mem_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    mem_valid_i |=> (!mem_valid_i || (mem_rd_i != $past(mem_rd_i))))
    else begin
      assert_fail_cnt++;
      $error("memory valid held without a new issue");
    end

  // sources of an issued entry are free once its issue edge has passed
  alu_src_free: assert property (@(posedge clk) disable iff (!rst_n)
    alu_valid_i |-> (!busy_i[alu_src0_i] && !busy_i[alu_src1_i]))
    else begin
      assert_fail_cnt++;
      $error("ALU issued with a busy source");
    end

  mem_src_free: assert property (@(posedge clk) disable iff (!rst_n)
    mem_valid_i |-> (!busy_i[mem_src0_i] && !busy_i[mem_src1_i]))
    else begin
      assert_fail_cnt++;
      $error("memory issued with a busy source");
    end

endmodule

bind issue_stage tb_scheduler_asserts u_asserts (
  .clk         (clk),
  .rst_n       (rst_n),
  .dq_empty_i  (dq_empty_i),
  .dq_pop_i    (dq_pop_o),
  .alu_rd_i    (iq_rd[CLASS_ALU]),
  .mem_rd_i    (iq_rd[CLASS_MEM]),
  .busy_i      (busy),
  .alu_valid_i (alu_valid_o),
  .alu_src0_i  (alu_src0_o),
  .alu_src1_i  (alu_src1_o),
  .mem_valid_i (mem_valid_o),
  .mem_src0_i  (mem_src0_o),
  .mem_src1_i  (mem_src1_o)
);
